/* verilog/tx_pkg.sv */
package tx_pkg;

    // Widths of the data path
    localparam int WORD_W = 16;         // Parallel word
    localparam int QUAD_W = 4;          // Half-rate stage output
    localparam int PRBS_W = 15;         // LFSR length
    localparam int QUADS_PER_WORD = WORD_W / QUAD_W;

    typedef logic [WORD_W-1:0] word_t;         // Parallel data word
    typedef logic [QUAD_W-1:0] quad_t;         // One quad, lane 0 leaves first
    typedef logic [PRBS_W-1:0] prbs_state_t;   // PRBS-15 shift register

    // Where the next word comes from
    typedef enum logic [1:0] {
        SRC_TRAIN = 2'd0,   // Fixed training pattern
        SRC_PRBS  = 2'd1,   // Internal generator
        SRC_DIN   = 2'd2    // Parallel input port
    } tx_src_t;

    // Lane control states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // Pair parked at idle level
        ST_TRAIN = 2'd1,    // Training words back to back
        ST_DATA  = 2'd2     // Locked, payload words
    } tx_state_t;

    // Defaults handed down by the top level
    localparam word_t TRAIN_WORD_DEF = 16'hF0AA;
    localparam int TRAIN_WORDS_DEF = 4;             // Words sent after enable
    localparam prbs_state_t PRBS_SEED_DEF = 15'h7FFF; // Any non-zero value

endpackage

/* verilog/tx_ctrl.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_ctrl #(
    parameter int TRAIN_WORDS = tx_pkg::TRAIN_WORDS_DEF     // Training words per enable
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic en,            // Lane enable level
    input wire logic sel_prbs,      // PRBS over din in data mode

    output logic word_load,         // Every 16th cycle while active
    output logic quad_load,         // Every 4th cycle while active
    output logic prbs_step,         // Generator advance
    output logic tx_on,             // Lane active
    output logic locked,            // Data mode
    output tx_pkg::tx_src_t word_src,
    output logic word_strobe        // din taken at this edge
);

import tx_pkg::*;

// Training counter sized from the parameter
localparam int TW_W = (TRAIN_WORDS > 1) ? $clog2(TRAIN_WORDS) : 1;
localparam logic [TW_W-1:0] TW_LAST = TW_W'(TRAIN_WORDS - 1);

tx_state_t state;
logic [3:0] bit_cnt;            // Bit slot inside the current word
logic [TW_W-1:0] train_cnt;     // Training words already loaded
logic word_end;                 // Last bit slot of a word

assign word_end = (bit_cnt == 4'd15);

// Main FSM, en low drops back to idle at any edge
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= ST_IDLE;
        bit_cnt <= 4'd0;
        train_cnt <= '0;
    end else if (!en) begin
        state <= ST_IDLE;       // Partial word discarded
        bit_cnt <= 4'd0;
        train_cnt <= '0;
    end else begin
        case (state)
            ST_IDLE: begin
                state <= ST_TRAIN;      // First word_load on the next edge
                bit_cnt <= 4'd0;
                train_cnt <= '0;
            end
            ST_TRAIN: begin
                bit_cnt <= bit_cnt + 4'd1;
                if (word_end) begin
                    if (train_cnt == TW_LAST) begin
                        state <= ST_DATA;   // Next slot 0 carries data
                    end else begin
                        train_cnt <= train_cnt + 1'b1;
                    end
                end
            end
            ST_DATA: begin
                bit_cnt <= bit_cnt + 4'd1;  // Wraps every word
            end
            default: begin
                state <= ST_IDLE;
            end
        endcase
    end
end

// Strobes decoded from the counters
assign tx_on = (state != ST_IDLE);
assign word_load = tx_on && (bit_cnt == 4'd0);
assign quad_load = tx_on && (bit_cnt[1:0] == 2'd0);    // Quad 0 lines up with word_load
assign locked = (state == ST_DATA);

// Source choice, only consumed on word_load edges
always_comb begin
    case (state)
        ST_DATA: word_src = sel_prbs ? SRC_PRBS : SRC_DIN;
        default: word_src = SRC_TRAIN;
    endcase
end

assign prbs_step = word_load && (word_src == SRC_PRBS);
assign word_strobe = word_load && (word_src == SRC_DIN);   // Only din-sourced words

endmodule

`default_nettype wire

/* verilog/prbs_gen.sv */
`timescale 1ns/10ps

`default_nettype none

module prbs_gen #(
    parameter tx_pkg::prbs_state_t PRBS_SEED = tx_pkg::PRBS_SEED_DEF
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic step,          // Advance by one word
    output tx_pkg::word_t prbs_word // Bits of the upcoming step
);

import tx_pkg::*;

prbs_state_t lfsr;
prbs_state_t lfsr_next;     // State after 16 shifts

// Unrolled x^15+x^14+1, first generated bit lands in bit 15
always_comb begin : unroll
    prbs_state_t s;
    logic fb;
    s = lfsr;
    for (int i = 0; i < WORD_W; i++) begin
        fb = s[14] ^ s[13];             // Taps 15 and 14
        prbs_word[WORD_W-1-i] = fb;     // MSB first
        s = {s[13:0], fb};
    end
    lfsr_next = s;
end

// One word per step
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        lfsr <= PRBS_SEED;
    end else if (step) begin
        lfsr <= lfsr_next;
    end
end

endmodule

`default_nettype wire

/* verilog/hr_16t4_mux.sv */
`timescale 1ns/10ps

`default_nettype none

module hr_16t4_mux #(
    parameter tx_pkg::word_t TRAIN_WORD = tx_pkg::TRAIN_WORD_DEF
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic word_load,             // Take a new word
    input wire logic quad_load,             // Issue the next quad
    input wire tx_pkg::tx_src_t word_src,
    input wire tx_pkg::word_t din,          // Parallel input
    input wire tx_pkg::word_t prbs_word,    // Generator output
    output tx_pkg::quad_t quad              // To the quarter-rate stage
);

import tx_pkg::*;

word_t sel_word;    // Chosen source
word_t il_word;     // Interleaved, quad n at [4n+3:4n]
word_t word_reg;    // Quads still waiting

// Source mux
always_comb begin
    case (word_src)
        SRC_PRBS: sel_word = prbs_word;
        SRC_DIN:  sel_word = din;
        default:  sel_word = TRAIN_WORD;
    endcase
end

// Lane j of quad n carries word bit 15-4n-j
always_comb begin
    for (int n = 0; n < QUADS_PER_WORD; n++) begin
        for (int j = 0; j < QUAD_W; j++) begin
            il_word[QUAD_W*n + j] = sel_word[WORD_W-1 - QUAD_W*n - j];
        end
    end
end

// Output quad register
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        quad <= '0;
    end else if (quad_load) begin
        quad <= word_load ? il_word[QUAD_W-1:0]     // Quad 0 straight through
                          : word_reg[QUAD_W-1:0];
    end
end

// Remaining quads shift down by one quad per load
always_ff @(posedge clk) begin
    if (word_load) begin
        word_reg <= il_word >> QUAD_W;
    end else if (quad_load) begin
        word_reg <= word_reg >> QUAD_W;
    end
end

endmodule

`default_nettype wire

/* verilog/qr_4t1_mux.sv */
`timescale 1ns/10ps

`default_nettype none

module qr_4t1_mux (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic quad_load,         // Quad valid one cycle later
    input wire logic tx_on,             // Lane active
    input wire tx_pkg::quad_t quad,     // From half-rate stage
    output logic dout_p,                // Serial data
    output logic dout_n                 // Its complement
);

import tx_pkg::*;

quad_t sr;          // Bit shifter, bit 0 goes out next
logic ld_q;         // quad_load delayed to match the quad register
logic on_q;         // tx_on seen at the previous edge

// Control delays
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ld_q <= 1'b0;
        on_q <= 1'b0;
    end else begin
        ld_q <= quad_load;
        on_q <= tx_on;
    end
end

// Lane 0 first, then 1, 2, 3
always_ff @(posedge clk) begin
    if (!tx_on) begin
        sr <= '0;               // Flush stale bits while idle
    end else if (ld_q) begin
        sr <= quad;
    end else begin
        sr <= sr >> 1;
    end
end

// Output pair, idle is p low and n high
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        dout_p <= 1'b0;
        dout_n <= 1'b1;
    end else if (!on_q) begin
        dout_p <= 1'b0;         // Forced idle
        dout_n <= 1'b1;
    end else begin
        dout_p <= sr[0];
        dout_n <= ~sr[0];       // Registered complement
    end
end

endmodule

`default_nettype wire

/* verilog/tx_top.sv */
`timescale 1ns/10ps

`default_nettype none

module tx_top #(
    parameter tx_pkg::word_t TRAIN_WORD = tx_pkg::TRAIN_WORD_DEF,       // Training pattern
    parameter int TRAIN_WORDS = tx_pkg::TRAIN_WORDS_DEF,                // Words after enable
    parameter tx_pkg::prbs_state_t PRBS_SEED = tx_pkg::PRBS_SEED_DEF    // LFSR start value
) (
    input wire logic clk,               // Bit-rate clock
    input wire logic rst_n,
    input wire logic en,                // Lane enable
    input wire logic sel_prbs,          // PRBS instead of din
    input wire tx_pkg::word_t din,      // Sampled at word_strobe

    output logic word_strobe,           // din taken
    output logic locked,                // Data mode
    output logic dout_p,                // Serial pair
    output logic dout_n
);

import tx_pkg::*;

// Control strobes
logic word_load;
logic quad_load;
logic prbs_step;
logic tx_on;
tx_src_t word_src;

// Data path
word_t prbs_word;   // Generator to half-rate stage
quad_t quad;        // Half-rate to quarter-rate stage

// Counters, FSM and all strobes
tx_ctrl #(
    .TRAIN_WORDS(TRAIN_WORDS)
) ctrl0 (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .sel_prbs(sel_prbs),
    .word_load(word_load),
    .quad_load(quad_load),
    .prbs_step(prbs_step),
    .tx_on(tx_on),
    .locked(locked),
    .word_src(word_src),
    .word_strobe(word_strobe)
);

// PRBS-15 word source
prbs_gen #(
    .PRBS_SEED(PRBS_SEED)
) prbs0 (
    .clk(clk),
    .rst_n(rst_n),
    .step(prbs_step),
    .prbs_word(prbs_word)
);

// Word to quads
hr_16t4_mux #(
    .TRAIN_WORD(TRAIN_WORD)
) hr_mux_16t4_0 (
    .clk(clk),
    .rst_n(rst_n),
    .word_load(word_load),
    .quad_load(quad_load),
    .word_src(word_src),
    .din(din),
    .prbs_word(prbs_word),
    .quad(quad)
);

// Quads to bits, drives the pair
qr_4t1_mux qr_mux_4t1_0 (
    .clk(clk),
    .rst_n(rst_n),
    .quad_load(quad_load),
    .tx_on(tx_on),
    .quad(quad),
    .dout_p(dout_p),
    .dout_n(dout_n)
);

endmodule

`default_nettype wire

/* tb/tx_ref.svh */
`ifndef TX_REF_SVH
`define TX_REF_SVH

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// PRBS-15 with x^15+x^14+1, 16 output bits per call
// st[0] is the newest bit, st[14] the oldest
function automatic word_t prbs_next16(inout prbs_state_t st);
    word_t w;
    logic nb;
    int k;
    w = '0;
    for (k = 0; k < 16; k++) begin
        nb = st[14] ^ st[13];       // b(n) = b(n-15) ^ b(n-14)
        w = {w[14:0], nb};          // First bit drifts up to bit 15
        st = {st[13:0], nb};
    end
    return w;
endfunction

// Source of word idx within one enable session
function automatic tx_src_t word_source(input int idx, input logic sel);
    tx_src_t src;
    if (idx < TRAIN_WORDS_DEF) begin
        src = SRC_TRAIN;            // Training run after enable
    end else if (sel) begin
        src = SRC_PRBS;
    end else begin
        src = SRC_DIN;
    end
    return src;
endfunction

// Next word of the expected serial stream, sent MSB first
function automatic word_t expected_word(input tx_src_t src, input word_t din_val,
                                        inout prbs_state_t st);
    word_t w;
    case (src)
        SRC_TRAIN: w = TRAIN_WORD_DEF;
        SRC_PRBS:  w = prbs_next16(st);     // Model steps with the generator
        default:   w = din_val;             // Value held at word_strobe
    endcase
    return w;
endfunction

`endif

/* tb/tx_top_tb.sv */
`timescale 1ns/10ps

module tx_top_tb;

import tx_pkg::*;

logic clk = 1'b0;
logic rst_n;
logic en;
logic sel_prbs;
word_t din;
logic word_strobe;
logic locked;
logic dout_p;
logic dout_n;

int cyc = 0;                // Rising edges so far
int sess_start;             // Edge that samples en high
int n_words;                // Words compared in this session
int words_done;             // Words compared in this session so far
bit active;                 // Capture running
logic [31:0] rnd;           // xorshift state
prbs_state_t ref_lfsr;      // Generator model
word_t rx_shift;            // Serial bits being gathered
word_t exp_q[$];            // Expected words, send order
word_t rx_q[$];             // Words read off dout_p
event word_done;

`include "tx_ref.svh"

tx_top #(
    .TRAIN_WORD(TRAIN_WORD_DEF),
    .TRAIN_WORDS(TRAIN_WORDS_DEF),
    .PRBS_SEED(PRBS_SEED_DEF)
) tx_top_inst (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .sel_prbs(sel_prbs),
    .din(din),
    .word_strobe(word_strobe),
    .locked(locked),
    .dout_p(dout_p),
    .dout_n(dout_n)
);

always #20 clk = ~clk;      // 40 ns period

always @(posedge clk) cyc <= cyc + 1;

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, want));
    end
endtask

task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
        abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, want));
    end
endtask

task automatic drive_random_din();
    rnd = xorshift32(rnd);
    din = rnd[15:0];
endtask

// Pair parked, no strobes, not locked
task automatic check_idle(input int n);
    repeat (n) begin
        @(negedge clk);
        check_bit("dout_p", dout_p, 1'b0);
        check_bit("dout_n", dout_n, 1'b1);
        check_bit("locked", locked, 1'b0);
        check_bit("word_strobe", word_strobe, 1'b0);
    end
endtask

task automatic wait_strobe(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (word_strobe !== 1'b1) begin
        n++;
        if (n > limit) abort_run("timed out waiting for word_strobe");
        @(negedge clk);
    end
endtask

task automatic wait_words(input int count, input int limit);
    int n;
    n = 0;
    while (words_done < count) begin
        n++;
        if (n > limit) abort_run("timed out waiting for serial words on dout_p");
        @(posedge clk);
        #2;
    end
endtask

// Enable, n_din words from din, then n_prbs words from the generator
task automatic run_session(input int n_din, input int n_prbs);
    int i;
    @(posedge clk);
    #2;
    n_words = TRAIN_WORDS_DEF + n_din + n_prbs;
    words_done = 0;
    sess_start = cyc + 1;
    sel_prbs = (n_din == 0);
    drive_random_din();
    active = 1'b1;
    en = 1'b1;
    for (i = 0; i < n_din; i++) begin
        wait_strobe(100);
        @(posedge clk);             // din taken at this edge
        #2;
        drive_random_din();
        if (i == n_din - 1) sel_prbs = 1'b1;    // Next load picks PRBS
    end
    wait_words(n_words, 16 * n_words + 100);
endtask

// en low mid word, pair idle two edges later
task automatic drop_enable();
    active = 1'b0;
    en = 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_bit("locked", locked, 1'b0);      // Cleared where en is sampled low
    check_bit("word_strobe", word_strobe, 1'b0);
    @(negedge clk);                         // Last bits may still leave
    check_idle(8);
endtask

// Sample at the falling edge, well away from drive and update times
always @(negedge clk) begin : capture
    int offs;
    tx_src_t src;
    word_t want;
    check_bit("dout_n", dout_n, ~dout_p);
    if (active) begin
        offs = cyc - sess_start;
        if (offs >= 0 && offs % 16 == 0) begin      // word_load cycle
            src = word_source(offs / 16, sel_prbs);
            check_bit("locked", locked, offs / 16 >= TRAIN_WORDS_DEF);
            check_bit("word_strobe", word_strobe, src == SRC_DIN);
            want = expected_word(src, din, ref_lfsr);
            if (offs / 16 < n_words) exp_q.push_back(want);
        end else begin
            check_bit("word_strobe", word_strobe, 1'b0);
        end
        if (offs >= 3 && offs < 3 + 16 * n_words) begin    // Bit 15 two edges after load
            rx_shift = {rx_shift[14:0], dout_p};
            if ((offs - 3) % 16 == 15) begin
                rx_q.push_back(rx_shift);
                -> word_done;
            end
        end
    end
end

always @(word_done) begin : compare
    word_t got;
    while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) abort_run("a serial word arrived with no expected word");
        check_word("dout_p word", got, exp_q.pop_front());
        words_done++;
    end
end

initial begin : stimulus
    rst_n = 1'b0;
    en = 1'b0;
    sel_prbs = 1'b0;
    din = '0;
    active = 1'b0;
    n_words = 0;
    words_done = 0;
    sess_start = 0;
    rx_shift = '0;
    rnd = 32'h2e45;
    ref_lfsr = PRBS_SEED_DEF;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_idle(8);
    run_session(20, 12);        // Training, din words, PRBS words
    drop_enable();
    run_session(3, 2);          // Training again after re-enable
    drop_enable();
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

/* build.f */
+incdir+tb
verilog/tx_pkg.sv
verilog/tx_ctrl.sv
verilog/prbs_gen.sv
verilog/hr_16t4_mux.sv
verilog/qr_4t1_mux.sv
verilog/tx_top.sv
tb/tx_top_tb.sv
